// File: Makefile
SIM  := obj_dir/Vvideo_tb
SRCS := $(shell grep -v '^+' build.f) verilog/video_settings.svh

.PHONY: all run clean

all: run

$(SIM): build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module video_tb -o Vvideo_tb

run: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
+incdir+verilog
verilog/video_pkg.sv
verilog/pxl_align.sv
verilog/video_ctrl.sv
verilog/char_layer.sv
verilog/star_layer.sv
verilog/colmix.sv
verilog/video_top.sv
test/tb_clk.sv
test/video_tb.sv

// File: test/tb_clk.sv
// Testbench clock source
// Free-running clock, 8 ns period by default
`timescale 1ns/10ps

module tb_clk #(
    parameter real PERIOD = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2.0) clk = ~clk;

endmodule

// File: test/video_tb.sv
// Testbench for the tile video generator
// Directed register, layer, priority and back-pressure tests against a pixel model
`timescale 1ns/10ps
`include "video_settings.svh"

module video_tb;
    import video_pkg::*;

    localparam int FRAME_CYC = `VID_HTOTAL * `VID_VTOTAL;
    localparam int NPIX      = `VID_HVIS * `VID_VVIS;
    localparam int TILES     = `VID_TILES_X * `VID_TILES_Y;
    // Up to 13 frames of waits and captures, two spare, plus bus traffic
    localparam int TIMEOUT_CYC = 15 * FRAME_CYC + 1600;

    logic        clk;
    logic        arst_n;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [11:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    video_out_t  vout;

    // Shadow copies of everything written to the DUT
    rgb_t        pal_sh   [`VID_PAL_SIZE];
    logic [6:0]  tile_sh  [TILES];
    logic [7:0]  glyph_sh [`VID_GLYPHS * 8];
    logic [1:0]  ctrl_sh;
    rgb_t        cap_buf  [NPIX];
    logic [31:0] lfsr_q;
    int          errors;
    int          checks;
    int          tests;
    int          cycles = 0;

    tb_clk #(.PERIOD(8.0)) u_clk (.clk(clk));

    video_top uut (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .awaddr  ( awaddr  ),
        .awvalid ( awvalid ),
        .awready ( awready ),
        .wdata   ( wdata   ),
        .wvalid  ( wvalid  ),
        .wready  ( wready  ),
        .bresp   ( bresp   ),
        .bvalid  ( bvalid  ),
        .bready  ( bready  ),
        .araddr  ( araddr  ),
        .arvalid ( arvalid ),
        .arready ( arready ),
        .rdata   ( rdata   ),
        .rresp   ( rresp   ),
        .rvalid  ( rvalid  ),
        .rready  ( rready  ),
        .vout    ( vout    )
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYC) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    // Pixel model: character over star over background
    function automatic rgb_t expected_pixel(input int x, input int y, input int offset);
        logic [6:0] tile;
        logic [7:0] row;
        logic [6:0] s;
        logic [3:0] v3;
        logic [2:0] star;
        logic       opaque;
        tile   = tile_sh[(y / 8) * `VID_TILES_X + x / 8];
        row    = glyph_sh[int'(tile[3:0]) * 8 + y % 8];
        opaque = ctrl_sh[0] && row[7 - x % 8];
        s      = 7'((x + offset) % 128);
        v3     = 4'((3 * y) % 16);
        star   = (ctrl_sh[1] && s[3:0] == v3) ? (s[6:4] ^ 3'(y % 8)) : 3'd0;
        if (opaque) begin
            return pal_sh[8 + int'(tile[6:4])];
        end
        if (star != 3'd0) begin
            return pal_sh[int'(star)];
        end
        return pal_sh[0];
    endfunction

    task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            if (errors <= 20) begin
                $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
            end
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s got resp %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_sync(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Inputs change 1 ns after the rising edge, outputs are read there too
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic [1:0] resp, input int stall = 0);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!awready) step();
        check_sync(wready, 1'b1, "wready with awready");
        step();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) step();
        repeat (stall) step();
        resp   = bresp;
        bready = 1'b1;
        step();
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic [1:0] resp, input int stall = 0);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) step();
        step();
        arvalid = 1'b0;
        while (!rvalid) step();
        repeat (stall) step();
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        step();
        rready = 1'b0;
    endtask

    task automatic write_ok(input logic [11:0] addr, input logic [31:0] data,
                            input int stall = 0);
        logic [1:0] resp;
        axi_write(addr, data, resp, stall);
        check_resp(resp, 2'd0, $sformatf("write to %h", addr));
    endtask

    task automatic read_check(input logic [11:0] addr, input logic [31:0] exp,
                              input int stall = 0);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, data, resp, stall);
        check_resp(resp, 2'd0, $sformatf("read from %h", addr));
        check_word(data, exp, $sformatf("read from %h", addr));
    endtask

    task automatic wait_vsync();
        while (vout.vsync) step();
        while (!vout.vsync) step();
    endtask

    // Next full frame after vsync, blanked pixels must be black
    // Sync flags follow the line position from the first visible pixel on
    task automatic capture_frame();
        int   n;
        int   col;
        logic prev_de;
        n       = 0;
        col     = -1;
        prev_de = 1'b0;
        wait_vsync();
        while (n < NPIX) begin
            step();
            if (vout.de && !prev_de) begin
                col = 0;
            end else if (col >= 0) begin
                col = (col + 1) % `VID_HTOTAL;
            end
            prev_de = vout.de;
            if (col >= 0) begin
                check_sync(vout.hsync,
                           col >= `VID_HSYNC_START && col < `VID_HSYNC_START + 4,
                           $sformatf("hsync at column %0d", col));
                check_sync(vout.vsync, 1'b0, "vsync in visible lines");
            end
            if (vout.de) begin
                cap_buf[n] = vout.rgb;
                n++;
            end else begin
                check_rgb(vout.rgb, rgb_t'(12'd0), "blanking");
            end
        end
    endtask

    task automatic check_frame(input int offset);
        for (int p = 0; p < NPIX; p++) begin
            check_rgb(cap_buf[p], expected_pixel(p % `VID_HVIS, p / `VID_HVIS, offset),
                      $sformatf("pixel x=%0d y=%0d", p % `VID_HVIS, p / `VID_HVIS));
        end
    endtask

    // Star offset is not visible on the bus, so search for it
    function automatic int find_offset();
        int bad;
        for (int off = 0; off < 128; off++) begin
            bad = 0;
            for (int p = 0; p < NPIX && bad == 0; p++) begin
                if (cap_buf[p] !== expected_pixel(p % `VID_HVIS, p / `VID_HVIS, off)) begin
                    bad++;
                end
            end
            if (bad == 0) begin
                return off;
            end
        end
        return -1;
    endfunction

    task automatic locate_stars(input string what, output int off);
        checks++;
        off = find_offset();
        if (off < 0) begin
            errors++;
            $display("[ERROR] %0t ns: %s matches no star offset", $time, what);
        end
    endtask

    task automatic report_test(input string name, input int e0);
        tests++;
        if (errors == e0) begin
            $display("test %-14s ok", name);
        end else begin
            $display("test %-14s failed with %0d errors", name, errors - e0);
        end
    endtask

    task automatic test_registers();
        int          e0;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [1:0]  resp;
        rgb_t        c;
        e0 = errors;
        write_ok(12'h000, 32'h3);
        read_check(12'h000, 32'h3);
        write_ok(12'h000, 32'h0);
        ctrl_sh = 2'b00;
        read_check(12'h000, 32'h0);
        write_ok(12'h004, 32'h9);
        read_check(12'h004, 32'h9);
        for (int i = 0; i < `VID_PAL_SIZE; i++) begin
            c = rgb_t'(12'(rand_bits(12)));
            write_ok(12'(64 + 4 * i), 32'(c));
            pal_sh[i] = c;
        end
        for (int i = 0; i < `VID_PAL_SIZE; i++) begin
            read_check(12'(64 + 4 * i), 32'(pal_sh[i]));
        end
        axi_write(12'hff0, 32'h1, resp);
        check_resp(resp, 2'd2, "write to unmapped ff0");
        axi_read(12'hff0, f0, resp);
        check_resp(resp, 2'd2, "read from unmapped ff0");
        // Exactly one frame start lies between two vsyncs
        wait_vsync();
        axi_read(12'h008, f0, resp);
        wait_vsync();
        axi_read(12'h008, f1, resp);
        check_word(f1, f0 + 1, "frame counter one frame later");
        report_test("registers", e0);
    endtask

    task automatic test_background();
        int e0;
        e0 = errors;
        write_ok(12'h000, 32'h0);
        ctrl_sh = 2'b00;
        capture_frame();
        check_frame(0);
        report_test("background", e0);
    endtask

    task automatic test_chars();
        int e0;
        e0 = errors;
        for (int i = 0; i < `VID_GLYPHS * 8; i++) begin
            glyph_sh[i] = 8'(rand_bits(8));
            write_ok(12'(512 + 4 * i), 32'(glyph_sh[i]));
        end
        for (int i = 0; i < TILES; i++) begin
            tile_sh[i] = 7'(rand_bits(7));
            write_ok(12'(256 + 4 * i), 32'(tile_sh[i]));
        end
        write_ok(12'h000, 32'h1);
        ctrl_sh = 2'b01;
        capture_frame();
        check_frame(0);
        report_test("characters", e0);
    endtask

    task automatic test_stars();
        int   e0;
        int   off;
        rgb_t c;
        e0 = errors;
        // Low nibble is the index, so every star colour is distinct
        for (int i = 0; i < `VID_PAL_SIZE; i++) begin
            c = rgb_t'({8'(rand_bits(8)), 4'(i)});
            write_ok(12'(64 + 4 * i), 32'(c));
            pal_sh[i] = c;
        end
        write_ok(12'h004, 32'h3);
        write_ok(12'h000, 32'h2);
        ctrl_sh = 2'b10;
        capture_frame();
        locate_stars("first star frame", off);
        capture_frame();
        if (off >= 0) begin
            check_frame((off + 3) % 128);
        end
        report_test("stars", e0);
    endtask

    task automatic test_priority();
        int e0;
        int off;
        e0 = errors;
        write_ok(12'h000, 32'h3);
        ctrl_sh = 2'b11;
        capture_frame();
        locate_stars("mixed frame", off);
        report_test("priority", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        int off;
        e0 = errors;
        fork
            capture_frame();
            begin
                write_ok(12'h000, 32'h3, 3);
                read_check(12'h000, 32'h3, 4);
                write_ok(12'h004, 32'h5, 2);
                read_check(12'h004, 32'h5, 6);
                for (int i = 0; i < 4; i++) begin
                    read_check(12'(64 + 4 * i), 32'(pal_sh[i]), i + 1);
                end
            end
        join
        locate_stars("frame under bus stalls", off);
        report_test("backpressure", e0);
    endtask

    initial begin
        errors  = 0;
        checks  = 0;
        tests   = 0;
        lfsr_q  = 32'hd9e43c55;
        ctrl_sh = 2'b00;
        arst_n  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        step();

        test_registers();
        test_background();
        test_chars();
        test_stars();
        test_priority();
        test_backpressure();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog/char_layer.sv
// Character layer of 8x8 tiles
// Tile map and glyph memories with a two-stage pixel lookup
`timescale 1ns/10ps
`include "video_settings.svh"

module char_layer (
    input  logic                  clk,
    input  video_pkg::raster_t    raster,
    input  logic                  char_on,
    input  video_pkg::mem_wr_t    mem_wr,
    output video_pkg::char_pxl_t  pxl
);
    import video_pkg::*;

    localparam int TILES  = `VID_TILES_X * `VID_TILES_Y;
    localparam int TILE_W = $clog2(TILES);
    localparam int GLW    = $clog2(`VID_GLYPHS);

    // Tile entry: colour in 6:4, glyph in 3:0
    logic [6:0]        tile_mem  [TILES];
    logic [7:0]        glyph_mem [`VID_GLYPHS * 8];
    logic [TILE_W-1:0] tile_idx;
    logic [6:0]        tile_q;
    logic [2:0]        row_q;
    logic [2:0]        col_q;
    logic              de_q;
    logic [7:0]        glyph_row;

    assign tile_idx = TILE_W'(raster.v[VW-1:3]) * TILE_W'(`VID_TILES_X) +
                      TILE_W'(raster.h[HW-1:3]);

    always_ff @(posedge clk) begin
        if (mem_wr.target == MEM_TILE) begin
            tile_mem[mem_wr.addr[TILE_W-1:0]] <= mem_wr.data[6:0];
        end
        if (mem_wr.target == MEM_GLYPH) begin
            glyph_mem[mem_wr.addr[GLW+2:0]] <= mem_wr.data[7:0];
        end
    end

    // Stage 1, tile entry
    always_ff @(posedge clk) begin
        if (raster.de) begin
            tile_q <= tile_mem[tile_idx];
        end
        row_q <= raster.v[2:0];
        col_q <= raster.h[2:0];
        de_q  <= raster.de;
    end

    // Stage 2, glyph row and bit select
    assign glyph_row = glyph_mem[{tile_q[GLW-1:0], row_q}];

    always_ff @(posedge clk) begin
        pxl.opaque <= glyph_row[3'd7 - col_q] && char_on && de_q;
        pxl.color  <= tile_q[6:4];
    end

    // Decoder in the control block must keep tile writes in range
    a_tile_range: assert property (@(posedge clk)
        mem_wr.target == MEM_TILE |-> mem_wr.addr < 8'(TILES));

endmodule

// File: verilog/colmix.sv
// Colour mixer
// Layer priority, palette lookup and registered RGB with blanking
`timescale 1ns/10ps
`include "video_settings.svh"

module colmix (
    input  logic                          clk,
    input  logic                          arst_n,
    input  video_pkg::raster_t            raster,
    input  video_pkg::char_pxl_t          char_pxl,
    input  video_pkg::star_pxl_t          star_pxl,
    input  video_pkg::mem_wr_t            mem_wr,
    input  logic [video_pkg::PAL_AW-1:0]  pal_rd_addr,
    output logic [11:0]                   pal_rd_data,
    output video_pkg::video_out_t         vout
);
    import video_pkg::*;

    rgb_t              pal_mem [`VID_PAL_SIZE];
    logic [PAL_AW-1:0] pal_idx;

    // Characters use the upper half of the palette
    always_comb begin
        if (char_pxl.opaque) begin
            pal_idx = PAL_AW'({1'b1, char_pxl.color});
        end else if (star_pxl.color != 3'd0) begin
            pal_idx = PAL_AW'(star_pxl.color);
        end else begin
            pal_idx = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr.target == MEM_PALETTE) begin
            pal_mem[mem_wr.addr[PAL_AW-1:0]] <= rgb_t'(mem_wr.data);
        end
        pal_rd_data <= pal_mem[pal_rd_addr];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vout <= '0;
        end else begin
            vout.rgb   <= raster.de ? pal_mem[pal_idx] : '0;
            vout.de    <= raster.de;
            vout.hsync <= raster.hsync;
            vout.vsync <= raster.vsync;
        end
    end

    a_blank_rgb: assert property (@(posedge clk) disable iff (!arst_n)
        !raster.de |=> vout.rgb == '0);

endmodule

// File: verilog/pxl_align.sv
// Delay line for layer alignment
// Carries any packed payload DLY cycles
`timescale 1ns/10ps

module pxl_align #(
    parameter type T   = logic,
    parameter int  DLY = 1
) (
    input  logic  clk,
    input  logic  arst_n,
    input  T      din,
    output T      dout
);

    T pipe [DLY];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DLY; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= din;
            for (int i = 1; i < DLY; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign dout = pipe[DLY-1];

endmodule

// File: verilog/star_layer.sv
// Scrolling star field
// One star per 16 columns, phase set by line and per-frame offset
`timescale 1ns/10ps

module star_layer (
    input  logic                  clk,
    input  logic                  arst_n,
    input  video_pkg::raster_t    raster,
    input  logic                  star_on,
    input  logic [3:0]            star_speed,
    output video_pkg::star_pxl_t  pxl
);
    import video_pkg::*;

    logic [6:0] offset;
    logic [6:0] off_use;
    logic [6:0] s;
    logic [3:0] v3;

    // New offset already applies on the frame_start pixel
    assign off_use = raster.frame_start ? offset + 7'(star_speed) : offset;
    assign s       = 7'(raster.h) + off_use;
    assign v3      = raster.v[3:0] + {raster.v[2:0], 1'b0};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            offset <= '0;
        end else if (raster.frame_start) begin
            offset <= off_use;
        end
    end

    always_ff @(posedge clk) begin
        if (star_on && raster.de && s[3:0] == v3) begin
            pxl.color <= s[6:4] ^ raster.v[2:0];
        end else begin
            pxl.color <= 3'd0;
        end
    end

endmodule

// File: verilog/video_ctrl.sv
// Video control block
// AXI4-Lite register file, memory write decode and raster counters
`timescale 1ns/10ps
`include "video_settings.svh"

module video_ctrl (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [11:0]                   awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [31:0]                   wdata,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [11:0]                   araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [31:0]                   rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,
    output logic [video_pkg::PAL_AW-1:0]  pal_rd_addr,
    input  logic [11:0]                   pal_rd_data,
    output video_pkg::raster_t            raster,
    output video_pkg::layer_ctrl_t        layer_ctrl,
    output video_pkg::mem_wr_t            mem_wr
);
    import video_pkg::*;

    localparam int TILES = `VID_TILES_X * `VID_TILES_Y;

    logic [HW-1:0]     h_cnt;
    logic [VW-1:0]     v_cnt;
    logic [15:0]       frame_cnt;
    logic [1:0]        ctrl_q;
    logic [3:0]        speed_q;
    logic              wr_go;
    logic              rd_go;
    mem_target_e       wr_target;
    logic [7:0]        wr_addr;
    logic              rd_pal;
    logic [PAL_AW-1:0] rd_pal_addr;
    logic [31:0]       rd_word;

    function automatic logic addr_mapped(input logic [11:0] a);
        return (a[11:2] <= 10'd2) || (a[11:6] == 6'h01) ||
               (a[11:8] == 4'h1 && a[7:2] < 6'(TILES)) || (a[11:9] == 3'h1);
    endfunction

    assign wready     = awready;
    assign wr_go      = awready && awvalid && wvalid;
    assign layer_ctrl = '{char_on: ctrl_q[0], star_on: ctrl_q[1], star_speed: speed_q};

    // Memory write target from the write address
    always_comb begin
        wr_target = MEM_NONE;
        wr_addr   = '0;
        if (awaddr[11:6] == 6'h01) begin
            wr_target = MEM_PALETTE;
            wr_addr   = 8'(awaddr[5:2]);
        end else if (awaddr[11:8] == 4'h1 && awaddr[7:2] < 6'(TILES)) begin
            wr_target = MEM_TILE;
            wr_addr   = 8'(awaddr[7:2]);
        end else if (awaddr[11:9] == 3'h1) begin
            wr_target = MEM_GLYPH;
            wr_addr   = 8'(awaddr[8:2]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            awready <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= 2'd0;
            ctrl_q  <= '0;
            speed_q <= '0;
            mem_wr  <= '0;
        end else begin
            // One-cycle ready, no new write while a response waits
            awready       <= awvalid && wvalid && !awready && !bvalid;
            mem_wr.target <= MEM_NONE;
            if (wr_go) begin
                bvalid <= 1'b1;
                bresp  <= addr_mapped(awaddr) ? 2'd0 : 2'd2;
                mem_wr <= '{target: wr_target, addr: wr_addr, data: wdata[11:0]};
                if (awaddr[11:2] == 10'd0) begin
                    ctrl_q <= wdata[1:0];
                end
                if (awaddr[11:2] == 10'd1) begin
                    speed_q <= wdata[3:0];
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Palette address stays on the accepted one while rvalid waits
    assign arready     = !rvalid;
    assign rd_go       = arvalid && arready;
    assign pal_rd_addr = rvalid ? rd_pal_addr : araddr[PAL_AW+1:2];
    assign rdata       = rd_pal ? 32'(pal_rd_data) : rd_word;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rvalid <= 1'b0;
            rresp  <= 2'd0;
            rd_pal <= 1'b0;
        end else if (rd_go) begin
            rvalid <= 1'b1;
            rresp  <= addr_mapped(araddr) ? 2'd0 : 2'd2;
            rd_pal <= araddr[11:6] == 6'h01;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            rd_pal_addr <= araddr[PAL_AW+1:2];
            case (araddr[11:2])
                10'd0:   rd_word <= 32'(ctrl_q);
                10'd1:   rd_word <= 32'(speed_q);
                10'd2:   rd_word <= 32'(frame_cnt);
                default: rd_word <= '0;
            endcase
        end
    end

    // Raster counters and timing flags
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt     <= '0;
            v_cnt     <= '0;
            raster    <= '0;
            frame_cnt <= '0;
        end else begin
            if (h_cnt == HW'(`VID_HTOTAL - 1)) begin
                h_cnt <= '0;
                v_cnt <= (v_cnt == VW'(`VID_VTOTAL - 1)) ? '0 : v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
            raster.h           <= h_cnt;
            raster.v           <= v_cnt;
            raster.de          <= h_cnt < HW'(`VID_HVIS) && v_cnt < VW'(`VID_VVIS);
            raster.hsync       <= h_cnt >= HW'(`VID_HSYNC_START) &&
                                  h_cnt <  HW'(`VID_HSYNC_START + 4);
            raster.vsync       <= v_cnt >= VW'(`VID_VSYNC_START) &&
                                  v_cnt <  VW'(`VID_VSYNC_START + 4);
            raster.frame_start <= h_cnt == '0 && v_cnt == '0;
            if (raster.frame_start) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(bresp));

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rresp));

endmodule

// File: verilog/video_pkg.sv
// Types shared by the tile video generator and its testbench
`include "video_settings.svh"

package video_pkg;

    localparam int HW     = $clog2(`VID_HTOTAL);
    localparam int VW     = $clog2(`VID_VTOTAL);
    localparam int PAL_AW = $clog2(`VID_PAL_SIZE);

    // One pixel slot of the raster
    typedef struct packed {
        logic [HW-1:0] h;
        logic [VW-1:0] v;
        logic          de;
        logic          hsync;
        logic          vsync;
        logic          frame_start;
    } raster_t;

    typedef struct packed {
        logic       char_on;
        logic       star_on;
        logic [3:0] star_speed;
    } layer_ctrl_t;

    typedef enum logic [1:0] {
        MEM_NONE    = 2'd0,
        MEM_TILE    = 2'd1,
        MEM_GLYPH   = 2'd2,
        MEM_PALETTE = 2'd3
    } mem_target_e;

    typedef struct packed {
        mem_target_e target;
        logic [7:0]  addr;
        logic [11:0] data;
    } mem_wr_t;

    typedef struct packed {
        logic       opaque;
        logic [2:0] color;
    } char_pxl_t;

    // Colour 0 means no star
    typedef struct packed {
        logic [2:0] color;
    } star_pxl_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    typedef struct packed {
        rgb_t rgb;
        logic de;
        logic hsync;
        logic vsync;
    } video_out_t;

endpackage

// File: verilog/video_settings.svh
// Sizes for the tile video generator
// Raster timing, tile map, palette and pipeline depths
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// Raster in pixel clocks and lines
`define VID_HTOTAL       64
`define VID_VTOTAL       40
`define VID_HVIS         48
`define VID_VVIS         32
`define VID_HSYNC_START  52
`define VID_VSYNC_START  34

// Character layer
`define VID_TILES_X      6
`define VID_TILES_Y      4
`define VID_GLYPHS       16

`define VID_PAL_SIZE     16
`define VID_CHAR_DLY     2

`endif

// File: verilog/video_top.sv
// Tile video generator top level
// Control block, character and star layers, alignment and colour mixer
`timescale 1ns/10ps
`include "video_settings.svh"

module video_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [11:0]            awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [31:0]            wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [11:0]            araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    output video_pkg::video_out_t  vout
);
    import video_pkg::*;

    raster_t           raster;
    raster_t           raster_dly;
    layer_ctrl_t       layer_ctrl;
    mem_wr_t           mem_wr;
    char_pxl_t         char_pxl;
    star_pxl_t         star_pxl;
    star_pxl_t         star_dly;
    logic [PAL_AW-1:0] pal_rd_addr;
    logic [11:0]       pal_rd_data;

    video_ctrl u_ctrl (
        .clk         ( clk          ),
        .arst_n      ( arst_n       ),
        .awaddr      ( awaddr       ),
        .awvalid     ( awvalid      ),
        .awready     ( awready      ),
        .wdata       ( wdata        ),
        .wvalid      ( wvalid       ),
        .wready      ( wready       ),
        .bresp       ( bresp        ),
        .bvalid      ( bvalid       ),
        .bready      ( bready       ),
        .araddr      ( araddr       ),
        .arvalid     ( arvalid      ),
        .arready     ( arready      ),
        .rdata       ( rdata        ),
        .rresp       ( rresp        ),
        .rvalid      ( rvalid       ),
        .rready      ( rready       ),
        .pal_rd_addr ( pal_rd_addr  ),
        .pal_rd_data ( pal_rd_data  ),
        .raster      ( raster       ),
        .layer_ctrl  ( layer_ctrl   ),
        .mem_wr      ( mem_wr       )
    );

    char_layer u_char (
        .clk         ( clk                ),
        .raster      ( raster             ),
        .char_on     ( layer_ctrl.char_on ),
        .mem_wr      ( mem_wr             ),
        .pxl         ( char_pxl           )
    );

    star_layer u_star (
        .clk         ( clk                   ),
        .arst_n      ( arst_n                ),
        .raster      ( raster                ),
        .star_on     ( layer_ctrl.star_on    ),
        .star_speed  ( layer_ctrl.star_speed ),
        .pxl         ( star_pxl              )
    );

    // Raster and stars wait for the slower character pipeline
    pxl_align #(
        .T   ( raster_t      ),
        .DLY ( `VID_CHAR_DLY )
    ) u_raster_dly (
        .clk    ( clk        ),
        .arst_n ( arst_n     ),
        .din    ( raster     ),
        .dout   ( raster_dly )
    );

    pxl_align #(
        .T   ( star_pxl_t        ),
        .DLY ( `VID_CHAR_DLY - 1 )
    ) u_star_dly (
        .clk    ( clk      ),
        .arst_n ( arst_n   ),
        .din    ( star_pxl ),
        .dout   ( star_dly )
    );

    colmix u_colmix (
        .clk         ( clk          ),
        .arst_n      ( arst_n       ),
        .raster      ( raster_dly   ),
        .char_pxl    ( char_pxl     ),
        .star_pxl    ( star_dly     ),
        .mem_wr      ( mem_wr       ),
        .pal_rd_addr ( pal_rd_addr  ),
        .pal_rd_data ( pal_rd_data  ),
        .vout        ( vout         )
    );

endmodule
